/* Makefile */
SRCS := $(shell grep '\.sv$$' sim.f) include/cfg_ctrl_params.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_cfg_ctrl: sim.f $(SRCS)
	verilator --binary --assert -f sim.f --top-module tb_cfg_ctrl

# The pipeline status is the status of grep, so a run without the pass line fails
run: obj_dir/Vtb_cfg_ctrl
	./obj_dir/Vtb_cfg_ctrl +verilator+error+limit+100 | tee /dev/stderr | \
		grep -c "Result: PASSED" > /dev/null

clean:
	rm -rf obj_dir

/* include/cfg_ctrl_params.svh */
`ifndef CFG_CTRL_PARAMS_SVH
`define CFG_CTRL_PARAMS_SVH

//////////////////////////////////////////////////
// Page map
//////////////////////////////////////////////////

// Target k sits at page base + k
`define CFG_PAGE_BASE     (20'h30000)
`define CFG_NUM_TGT       5
`define CFG_LOCAL_PAGE    (20'h30005)   // Controller registers

//////////////////////////////////////////////////
// Local register and default responder
//////////////////////////////////////////////////

`define CFG_SEL_OFFSET    (12'h000)     // User project select
`define CFG_DEFAULT_RDATA (32'hFFFFFFFF)

// Address bits passed on to the targets
`define CFG_DOWN_AW       15

`endif

/* sim.f */
+incdir+include
src/cfg_ctrl_pkg.sv
src/cfg_wb_port.sv
src/cfg_axil_port.sv
src/cfg_req_arbiter.sv
src/cfg_axil_master.sv
src/cfg_target_decode.sv
src/cfg_ctrl.sv
testbench/cfg_ctrl_asserts.sv
testbench/tb_cfg_ctrl.sv

/* src/cfg_axil_master.sv */
`timescale 1ns/1ns

`include "cfg_ctrl_params.svh"

module cfg_axil_master import cfg_ctrl_pkg::*; (
	input  logic       axi_clk,
	input  logic       axi_reset_n,
	input  cfg_req_t   req_i,
	output cfg_done_t  done_o,
	output logic       m_awvalid_o,
	output logic       m_wvalid_o,
	output logic       m_arvalid_o,
	output logic       m_rready_o,
	output down_addr_t m_awaddr_o,
	output down_addr_t m_araddr_o,
	output data_t      m_wdata_o,
	output strb_t      m_wstrb_o,
	output page_t      m_page_o,
	output logic       m_busy_o,
	input  tgt_rsp_t   rsp_i
);

	m_state_t   state;
	logic       stale;      // Request just completed, still asserted
	logic       done_q;
	data_t      rdata_q;
	down_addr_t daddr_q;
	page_t      page_q;
	logic       start;
	logic       aw_left;
	logic       w_left;
	logic       rd_done;

	assign start   = (state == m_idle) && req_i.valid && !stale;
	assign aw_left = m_awvalid_o && !rsp_i.awready;
	assign w_left  = m_wvalid_o && !rsp_i.wready;
	// Read data may come with arready or later
	assign rd_done = ((state == m_read_addr) || (state == m_read_wait)) && rsp_i.rvalid &&
		(!m_arvalid_o || rsp_i.arready);

	//////////////////////////////////////////////////
	// Transfer state machine
	//////////////////////////////////////////////////

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state       <= m_idle;
			m_awvalid_o <= 1'b0;
			m_wvalid_o  <= 1'b0;
			m_arvalid_o <= 1'b0;
			m_rready_o  <= 1'b0;
			done_q      <= 1'b0;
			stale       <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (!req_i.valid) begin
				stale <= 1'b0;
			end
			case (state)
				m_idle: begin
					if (start && req_i.rw) begin
						m_awvalid_o <= 1'b1;
						m_wvalid_o  <= 1'b1;
						state       <= m_write_addr;
					end else if (start) begin
						m_arvalid_o <= 1'b1;
						m_rready_o  <= 1'b1;   // Raised together with arvalid
						state       <= m_read_addr;
					end
				end
				m_write_addr, m_write_wait: begin
					// Each valid drops on its own ready
					m_awvalid_o <= aw_left;
					m_wvalid_o  <= w_left;
					if (!aw_left && !w_left) begin
						done_q <= 1'b1;
						stale  <= 1'b1;
						state  <= m_idle;
					end else if (!aw_left) begin
						state <= m_write_wait;   // Only data outstanding
					end
				end
				m_read_addr, m_read_wait: begin
					if (rsp_i.arready) begin
						m_arvalid_o <= 1'b0;
					end
					if (rd_done) begin
						m_rready_o <= 1'b0;
						done_q     <= 1'b1;
						stale      <= 1'b1;
						state      <= m_idle;
					end else if (m_arvalid_o && rsp_i.arready) begin
						state <= m_read_wait;
					end
				end
				default: state <= m_idle;
			endcase
		end
	end

	always_ff @(posedge axi_clk) begin
		if (start) begin
			page_q    <= req_i.addr[31:12];
			daddr_q   <= req_i.addr[`CFG_DOWN_AW-1:0];
			m_wdata_o <= req_i.data;
			m_wstrb_o <= req_i.strb;
		end
		if (rd_done) begin
			rdata_q <= rsp_i.rdata;
		end
	end

	assign m_awaddr_o = daddr_q;
	assign m_araddr_o = daddr_q;
	assign m_page_o   = page_q;
	assign m_busy_o   = (state != m_idle);
	assign done_o     = '{done: done_q, rdata: rdata_q};

endmodule

/* src/cfg_axil_port.sv */
`timescale 1ns/1ns

module cfg_axil_port import cfg_ctrl_pkg::*; (
	input  logic      axi_clk,
	input  logic      axi_reset_n,
	// Write address
	input  logic      s_awvalid_i,
	input  addr_t     s_awaddr_i,
	output logic      s_awready_o,
	// Write data
	input  logic      s_wvalid_i,
	input  data_t     s_wdata_i,
	input  strb_t     s_wstrb_i,
	output logic      s_wready_o,
	// Write response
	output logic      s_bvalid_o,
	input  logic      s_bready_i,
	// Read address
	input  logic      s_arvalid_i,
	input  addr_t     s_araddr_i,
	output logic      s_arready_o,
	// Read data
	output logic      s_rvalid_o,
	output data_t     s_rdata_o,
	input  logic      s_rready_i,
	// Arbiter side
	output cfg_req_t  req_o,
	input  cfg_done_t done_i
);

	s_state_t state;
	addr_t    req_addr;
	data_t    req_data;
	strb_t    req_strb;

	//////////////////////////////////////////////////
	// Port state machine
	//////////////////////////////////////////////////

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			state       <= s_idle;
			s_awready_o <= 1'b0;
			s_wready_o  <= 1'b0;
			s_arready_o <= 1'b0;
			s_bvalid_o  <= 1'b0;
			s_rvalid_o  <= 1'b0;
		end else begin
			// Readies are single pulses
			s_awready_o <= 1'b0;
			s_wready_o  <= 1'b0;
			s_arready_o <= 1'b0;
			case (state)
				s_idle: begin
					if (s_awvalid_i) begin    // Write wins over read
						s_awready_o <= 1'b1;
						state       <= s_write_data;
					end else if (s_arvalid_i) begin
						s_arready_o <= 1'b1;
						state       <= s_read_busy;
					end
				end
				s_write_data: begin
					if (s_wvalid_i) begin
						s_wready_o <= 1'b1;
						state      <= s_write_busy;
					end
				end
				s_write_busy: begin
					if (done_i.done) begin
						s_bvalid_o <= 1'b1;
						state      <= s_write_resp;
					end
				end
				s_write_resp: begin
					if (s_bready_i) begin
						s_bvalid_o <= 1'b0;
						state      <= s_idle;
					end
				end
				s_read_busy: begin
					if (done_i.done) begin
						s_rvalid_o <= 1'b1;
						state      <= s_read_resp;
					end
				end
				s_read_resp: begin
					if (s_rready_i) begin
						s_rvalid_o <= 1'b0;
						state      <= s_idle;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge axi_clk) begin
		if (state == s_idle) begin
			req_addr <= s_awvalid_i ? s_awaddr_i : s_araddr_i;
		end
		if (state == s_write_data && s_wvalid_i) begin
			req_data <= s_wdata_i;
			req_strb <= s_wstrb_i;
		end
		if (state == s_read_busy && done_i.done) begin
			s_rdata_o <= done_i.rdata;
		end
	end

	// Request is held straight from the busy states
	assign req_o = '{valid: (state == s_write_busy) || (state == s_read_busy),
		rw: (state == s_write_busy), addr: req_addr, data: req_data, strb: req_strb};

endmodule

/* src/cfg_ctrl.sv */
`timescale 1ns/1ns

`include "cfg_ctrl_params.svh"

module cfg_ctrl import cfg_ctrl_pkg::*; (
	input  logic       axi_clk,
	input  logic       axi_reset_n,
	// Wishbone slave
	input  logic       wbs_cyc_i,
	input  logic       wbs_stb_i,
	input  logic       wbs_we_i,
	input  addr_t      wbs_adr_i,
	input  data_t      wbs_wdata_i,
	input  strb_t      wbs_sel_i,
	output logic       wbs_ack_o,
	output data_t      wbs_rdata_o,
	// FPGA side AXI4-Lite slave
	input  logic       s_awvalid_i,
	input  addr_t      s_awaddr_i,
	output logic       s_awready_o,
	input  logic       s_wvalid_i,
	input  data_t      s_wdata_i,
	input  strb_t      s_wstrb_i,
	output logic       s_wready_o,
	output logic       s_bvalid_o,
	input  logic       s_bready_i,
	input  logic       s_arvalid_i,
	input  addr_t      s_araddr_i,
	output logic       s_arready_o,
	output logic       s_rvalid_o,
	output data_t      s_rdata_o,
	input  logic       s_rready_i,
	// Downstream AXI-Lite master
	output logic       m_awvalid_o,
	output down_addr_t m_awaddr_o,
	output logic       m_wvalid_o,
	output data_t      m_wdata_o,
	output strb_t      m_wstrb_o,
	output logic       m_arvalid_o,
	output down_addr_t m_araddr_o,
	output logic       m_rready_o,
	// Targets
	input  tgt_rsp_t   tgt_rsp_i [`CFG_NUM_TGT],
	output tgt_en_t    tgt_en_o,
	output prj_sel_t   user_prj_sel_o
);

	cfg_req_t  wb_req;
	cfg_req_t  fpga_req;
	cfg_req_t  m_req;
	cfg_done_t wb_done;
	cfg_done_t fpga_done;
	cfg_done_t m_done;
	page_t     m_page;
	logic      m_busy;
	tgt_rsp_t  tgt_rsp;     // Merged response of the selected target

	cfg_wb_port u_wb_port (
		.axi_clk     (axi_clk),
		.axi_reset_n (axi_reset_n),
		.wbs_cyc_i   (wbs_cyc_i),
		.wbs_stb_i   (wbs_stb_i),
		.wbs_we_i    (wbs_we_i),
		.wbs_adr_i   (wbs_adr_i),
		.wbs_wdata_i (wbs_wdata_i),
		.wbs_sel_i   (wbs_sel_i),
		.wbs_ack_o   (wbs_ack_o),
		.wbs_rdata_o (wbs_rdata_o),
		.req_o       (wb_req),
		.done_i      (wb_done)
	);

	cfg_axil_port u_axil_port (
		.axi_clk     (axi_clk),
		.axi_reset_n (axi_reset_n),
		.s_awvalid_i (s_awvalid_i),
		.s_awaddr_i  (s_awaddr_i),
		.s_awready_o (s_awready_o),
		.s_wvalid_i  (s_wvalid_i),
		.s_wdata_i   (s_wdata_i),
		.s_wstrb_i   (s_wstrb_i),
		.s_wready_o  (s_wready_o),
		.s_bvalid_o  (s_bvalid_o),
		.s_bready_i  (s_bready_i),
		.s_arvalid_i (s_arvalid_i),
		.s_araddr_i  (s_araddr_i),
		.s_arready_o (s_arready_o),
		.s_rvalid_o  (s_rvalid_o),
		.s_rdata_o   (s_rdata_o),
		.s_rready_i  (s_rready_i),
		.req_o       (fpga_req),
		.done_i      (fpga_done)
	);

	cfg_req_arbiter u_arbiter (
		.axi_clk     (axi_clk),
		.axi_reset_n (axi_reset_n),
		.wb_req_i    (wb_req),
		.fpga_req_i  (fpga_req),
		.wb_done_o   (wb_done),
		.fpga_done_o (fpga_done),
		.m_req_o     (m_req),
		.m_done_i    (m_done)
	);

	cfg_axil_master u_master (
		.axi_clk     (axi_clk),
		.axi_reset_n (axi_reset_n),
		.req_i       (m_req),
		.done_o      (m_done),
		.m_awvalid_o (m_awvalid_o),
		.m_wvalid_o  (m_wvalid_o),
		.m_arvalid_o (m_arvalid_o),
		.m_rready_o  (m_rready_o),
		.m_awaddr_o  (m_awaddr_o),
		.m_araddr_o  (m_araddr_o),
		.m_wdata_o   (m_wdata_o),
		.m_wstrb_o   (m_wstrb_o),
		.m_page_o    (m_page),
		.m_busy_o    (m_busy),
		.rsp_i       (tgt_rsp)
	);

	cfg_target_decode u_decode (
		.axi_clk        (axi_clk),
		.axi_reset_n    (axi_reset_n),
		.page_i         (m_page),
		.busy_i         (m_busy),
		.awvalid_i      (m_awvalid_o),
		.wvalid_i       (m_wvalid_o),
		.arvalid_i      (m_arvalid_o),
		.awaddr_i       (m_awaddr_o),
		.wdata_i        (m_wdata_o),
		.wstrb_i        (m_wstrb_o),
		.tgt_rsp_i      (tgt_rsp_i),
		.tgt_en_o       (tgt_en_o),
		.rsp_o          (tgt_rsp),
		.user_prj_sel_o (user_prj_sel_o)
	);

endmodule

/* src/cfg_ctrl_pkg.sv */
package cfg_ctrl_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;
	typedef logic [19:0] page_t;        // Top address bits
	typedef logic [14:0] down_addr_t;
	typedef logic [4:0]  prj_sel_t;

	// Bit 0 user subsystem, then LA, AXIS bridge, IO serdes, AXIL switch
	typedef logic [4:0]  tgt_en_t;

	// Requester port to arbiter
	typedef struct packed {
		logic  valid;
		logic  rw;      // Set for write
		addr_t addr;
		data_t data;
		strb_t strb;
	} cfg_req_t;

	// Completion back to a requester
	typedef struct packed {
		logic  done;
		data_t rdata;
	} cfg_done_t;

	// One downstream target response
	typedef struct packed {
		logic  awready;
		logic  wready;
		logic  arready;
		logic  rvalid;
		data_t rdata;
	} tgt_rsp_t;

	typedef enum logic [2:0] {
		m_idle,
		m_read_addr,
		m_read_wait,
		m_write_addr,
		m_write_wait
	} m_state_t;

	typedef enum logic [2:0] {
		s_idle,
		s_write_data,
		s_write_busy,
		s_write_resp,
		s_read_busy,
		s_read_resp
	} s_state_t;

endpackage

/* src/cfg_req_arbiter.sv */
`timescale 1ns/1ns

module cfg_req_arbiter import cfg_ctrl_pkg::*; (
	input  logic      axi_clk,
	input  logic      axi_reset_n,
	input  cfg_req_t  wb_req_i,
	input  cfg_req_t  fpga_req_i,
	output cfg_done_t wb_done_o,
	output cfg_done_t fpga_done_o,
	output cfg_req_t  m_req_o,
	input  cfg_done_t m_done_i
);

	logic grant_q;  // Low for Wishbone, high for FPGA port

	// Holder keeps the grant until it lets go of valid
	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			grant_q <= 1'b0;
		end else if (!grant_q && !wb_req_i.valid && fpga_req_i.valid) begin
			grant_q <= 1'b1;
		end else if (grant_q && !fpga_req_i.valid && wb_req_i.valid) begin
			grant_q <= 1'b0;
		end
	end

	assign m_req_o = grant_q ? fpga_req_i : wb_req_i;

	// Completion goes only to the grant holder
	always_comb begin
		wb_done_o        = m_done_i;
		fpga_done_o      = m_done_i;
		wb_done_o.done   = m_done_i.done && !grant_q;
		fpga_done_o.done = m_done_i.done && grant_q;
	end

endmodule

/* src/cfg_target_decode.sv */
`timescale 1ns/1ns

`include "cfg_ctrl_params.svh"

module cfg_target_decode import cfg_ctrl_pkg::*; (
	input  logic       axi_clk,
	input  logic       axi_reset_n,
	input  page_t      page_i,
	input  logic       busy_i,
	input  logic       awvalid_i,
	input  logic       wvalid_i,
	input  logic       arvalid_i,
	input  down_addr_t awaddr_i,
	input  data_t      wdata_i,
	input  strb_t      wstrb_i,
	input  tgt_rsp_t   tgt_rsp_i [`CFG_NUM_TGT],
	output tgt_en_t    tgt_en_o,
	output tgt_rsp_t   rsp_o,
	output prj_sel_t   user_prj_sel_o
);

	logic local_hit;
	logic dflt_hit;
	logic sel_wr;

	//////////////////////////////////////////////////
	// Page decode
	//////////////////////////////////////////////////

	always_comb begin
		for (int k = 0; k < `CFG_NUM_TGT; k++) begin
			tgt_en_o[k] = busy_i && (page_i == `CFG_PAGE_BASE + page_t'(k));
		end
	end

	assign local_hit = busy_i && (page_i == `CFG_LOCAL_PAGE);
	assign dflt_hit  = busy_i && !local_hit && (tgt_en_o == '0);   // Anything unmapped

	//////////////////////////////////////////////////
	// Response merge
	//////////////////////////////////////////////////

	always_comb begin
		rsp_o = '0;
		for (int k = 0; k < `CFG_NUM_TGT; k++) begin
			if (tgt_en_o[k]) begin
				rsp_o = tgt_rsp_i[k];   // Enables are one-hot
			end
		end
		if (local_hit) begin
			// Write needs address and data together
			rsp_o.awready = awvalid_i && wvalid_i;
			rsp_o.wready  = awvalid_i && wvalid_i;
			rsp_o.arready = 1'b1;
			rsp_o.rvalid  = 1'b1;
			rsp_o.rdata   = data_t'(user_prj_sel_o);
		end
		if (dflt_hit) begin
			// Accept everything at once
			rsp_o.awready = awvalid_i;
			rsp_o.wready  = wvalid_i;
			rsp_o.arready = arvalid_i;
			rsp_o.rvalid  = arvalid_i;
			rsp_o.rdata   = `CFG_DEFAULT_RDATA;
		end
	end

	// Select register sits at offset 0, byte lane 0
	assign sel_wr = local_hit && awvalid_i && wvalid_i &&
		(awaddr_i[11:0] == `CFG_SEL_OFFSET) && wstrb_i[0];

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			user_prj_sel_o <= '0;
		end else if (sel_wr) begin
			user_prj_sel_o <= wdata_i[$bits(prj_sel_t)-1:0];
		end
	end

endmodule

/* src/cfg_wb_port.sv */
`timescale 1ns/1ns

module cfg_wb_port import cfg_ctrl_pkg::*; (
	input  logic      axi_clk,
	input  logic      axi_reset_n,
	input  logic      wbs_cyc_i,
	input  logic      wbs_stb_i,
	input  logic      wbs_we_i,
	input  addr_t     wbs_adr_i,
	input  data_t     wbs_wdata_i,
	input  strb_t     wbs_sel_i,
	output logic      wbs_ack_o,
	output data_t     wbs_rdata_o,
	output cfg_req_t  req_o,
	input  cfg_done_t done_i
);

	logic  req_valid;   // Holder state, set while a request is out
	logic  req_rw;
	addr_t req_addr;
	data_t req_data;
	strb_t req_strb;
	logic  accept;
	logic  finish;

	// The ack cycle itself keeps a still-asserted stb from starting a new request
	assign accept = !req_valid && !wbs_ack_o && wbs_cyc_i && wbs_stb_i;
	assign finish = req_valid && done_i.done;

	always_ff @(posedge axi_clk or negedge axi_reset_n) begin
		if (!axi_reset_n) begin
			req_valid <= 1'b0;
			wbs_ack_o <= 1'b0;
		end else begin
			wbs_ack_o <= finish;    // One cycle pulse
			if (accept) begin
				req_valid <= 1'b1;
			end else if (finish) begin
				req_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge axi_clk) begin
		if (accept) begin
			req_rw   <= wbs_we_i;
			req_addr <= wbs_adr_i;
			req_data <= wbs_wdata_i;
			req_strb <= wbs_sel_i;
		end
		if (finish) begin
			wbs_rdata_o <= done_i.rdata;
		end
	end

	assign req_o = '{valid: req_valid, rw: req_rw, addr: req_addr,
		data: req_data, strb: req_strb};

endmodule

/* testbench/cfg_ctrl_asserts.sv */
`timescale 1ns/1ns

module cfg_ctrl_asserts import cfg_ctrl_pkg::*; (
	input logic     axi_clk,
	input logic     axi_reset_n,
	input logic     m_rready_i,
	input logic     m_awvalid_i,
	input logic     m_wvalid_i,
	input logic     m_arvalid_i,
	input tgt_rsp_t rsp_i,
	input tgt_en_t  tgt_en_i,
	input logic     s_bvalid_i,
	input logic     s_bready_i
);

	int fail_cnt = 0;   // Read by the testbench at the end

	//////////////////////////////////////////////////
	// Target enables
	//////////////////////////////////////////////////

	en_onehot: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		$onehot0(tgt_en_i))
	else begin
		$error("More than one target enable is high");
		fail_cnt++;
	end

	// Master idle means no downstream channel is open
	en_idle_low: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		!(m_awvalid_i || m_wvalid_i || m_arvalid_i || m_rready_i) |-> (tgt_en_i == '0))
	else begin
		$error("Target enable high while the master is idle");
		fail_cnt++;
	end

	//////////////////////////////////////////////////
	// Valids held until ready
	//////////////////////////////////////////////////

	aw_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		m_awvalid_i && !rsp_i.awready |=> m_awvalid_i)
	else begin
		$error("Downstream awvalid dropped without awready");
		fail_cnt++;
	end

	w_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		m_wvalid_i && !rsp_i.wready |=> m_wvalid_i)
	else begin
		$error("Downstream wvalid dropped without wready");
		fail_cnt++;
	end

	ar_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		m_arvalid_i && !rsp_i.arready |=> m_arvalid_i)
	else begin
		$error("Downstream arvalid dropped without arready");
		fail_cnt++;
	end

	// FPGA side write response
	b_hold: assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
		s_bvalid_i && !s_bready_i |=> s_bvalid_i)
	else begin
		$error("FPGA port bvalid dropped without bready");
		fail_cnt++;
	end

endmodule

bind cfg_ctrl cfg_ctrl_asserts u_asserts (
	.axi_clk     (axi_clk),
	.axi_reset_n (axi_reset_n),
	.m_rready_i  (m_rready_o),
	.m_awvalid_i (m_awvalid_o),
	.m_wvalid_i  (m_wvalid_o),
	.m_arvalid_i (m_arvalid_o),
	.rsp_i       (tgt_rsp),
	.tgt_en_i    (tgt_en_o),
	.s_bvalid_i  (s_bvalid_o),
	.s_bready_i  (s_bready_i)
);

/* testbench/tb_cfg_ctrl.sv */
`timescale 1ns/1ns

`include "cfg_ctrl_params.svh"

module tb_cfg_ctrl import cfg_ctrl_pkg::*; ();

	localparam int WAIT_LIMIT = 100;   // Cycles per wait loop

	logic       axi_clk;
	logic       axi_reset_n;
	logic       wbs_cyc_i;
	logic       wbs_stb_i;
	logic       wbs_we_i;
	addr_t      wbs_adr_i;
	data_t      wbs_wdata_i;
	strb_t      wbs_sel_i;
	logic       wbs_ack_o;
	data_t      wbs_rdata_o;
	logic       s_awvalid_i;
	addr_t      s_awaddr_i;
	logic       s_awready_o;
	logic       s_wvalid_i;
	data_t      s_wdata_i;
	strb_t      s_wstrb_i;
	logic       s_wready_o;
	logic       s_bvalid_o;
	logic       s_bready_i;
	logic       s_arvalid_i;
	addr_t      s_araddr_i;
	logic       s_arready_o;
	logic       s_rvalid_o;
	data_t      s_rdata_o;
	logic       s_rready_i;
	logic       m_awvalid_o;
	down_addr_t m_awaddr_o;
	logic       m_wvalid_o;
	data_t      m_wdata_o;
	strb_t      m_wstrb_o;
	logic       m_arvalid_o;
	down_addr_t m_araddr_o;
	logic       m_rready_o;
	tgt_rsp_t   tgt_rsp [`CFG_NUM_TGT];
	tgt_en_t    tgt_en_o;
	prj_sel_t   user_prj_sel_o;

	int         check_errs;
	int         wait_errs;
	data_t      exp_mem [`CFG_NUM_TGT][16];   // Expected target contents
	prj_sel_t   exp_sel;

	cfg_ctrl u_cfg_ctrl (.*, .tgt_rsp_i(tgt_rsp));

	initial begin
		axi_clk = 1'b0;
		forever begin
			#10 axi_clk = ~axi_clk;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Known start value for every target and word
	function automatic data_t fill_word(int k, int idx);
		return {8'hA5, 8'(k), 8'h3C, 8'(idx)};
	endfunction

	function automatic data_t merge_strb(data_t old, data_t nw, strb_t strb);
		data_t res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = nw[8*b +: 8];
			end
		end
		return res;
	endfunction

	function automatic addr_t tgt_addr(int k, int idx);
		return {page_t'(`CFG_PAGE_BASE + k), 10'(idx), 2'b00};
	endfunction

	function automatic tgt_en_t onehot(int k);
		return tgt_en_t'(1 << k);
	endfunction

	task automatic note_write(input int k, input int idx, input data_t wd, input strb_t strb);
		exp_mem[k][idx] = merge_strb(exp_mem[k][idx], wd, strb);
	endtask

	//////////////////////////////////////////////////
	// Target models
	//////////////////////////////////////////////////

	for (genvar k = 0; k < `CFG_NUM_TGT; k++) begin : g_tgt
		data_t    mem [16];
		tgt_rsp_t rsp_q = '0;
		int       delay = -1;   // Cycles left before ready, -1 when none chosen

		assign tgt_rsp[k] = rsp_q;

		always @(negedge axi_clk) begin : model
			logic [3:0] idx;
			rsp_q = '0;
			if (!axi_reset_n) begin
				for (int i = 0; i < 16; i++) begin
					mem[i] = fill_word(k, i);
				end
				delay = -1;
			end else if (!tgt_en_o[k] || !(m_awvalid_o || m_arvalid_o)) begin
				delay = -1;
			end else begin
				if (delay < 0) begin
					delay = $urandom % 4;
				end
				if (delay > 0) begin
					delay--;
				end else begin
					if (m_awvalid_o && m_wvalid_o) begin
						idx = m_awaddr_o[5:2];
						mem[idx] = merge_strb(mem[idx], m_wdata_o, m_wstrb_o);
						rsp_q.awready = 1'b1;
						rsp_q.wready  = 1'b1;
					end else if (m_arvalid_o && m_rready_o) begin   // Data only to a ready master
						idx = m_araddr_o[5:2];
						rsp_q.arready = 1'b1;
						rsp_q.rvalid  = 1'b1;   // Data comes with arready
						rsp_q.rdata   = mem[idx];
					end
					delay = -1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			check_errs++;
		end
	endtask

	task automatic check_sel(input string name, input prj_sel_t got, input prj_sel_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			check_errs++;
		end
	endtask

	task automatic check_en(input string name, input tgt_en_t got, input tgt_en_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			check_errs++;
		end
	endtask

	task automatic check_addr(input string name, input down_addr_t got, input down_addr_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			check_errs++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		wait_errs++;
	endtask

	// Decode and downstream address while a valid is up
	task automatic watch_bus(input addr_t adr, input tgt_en_t exp_en);
		if (m_awvalid_o || m_arvalid_o) begin
			check_en("tgt_en_o", tgt_en_o, exp_en);
		end
		if (m_awvalid_o) begin
			check_addr("m_awaddr_o", m_awaddr_o, adr[`CFG_DOWN_AW-1:0]);
		end
		if (m_arvalid_o) begin
			check_addr("m_araddr_o", m_araddr_o, adr[`CFG_DOWN_AW-1:0]);
		end
	endtask

	//////////////////////////////////////////////////
	// Bus drivers, called and left on a falling edge
	//////////////////////////////////////////////////

	task automatic wb_access(input logic we, input addr_t adr, input data_t wd,
			input strb_t sel, input logic chk, input tgt_en_t exp_en, output data_t rd);
		int cnt;
		cnt         = 0;
		wbs_we_i    = we;
		wbs_adr_i   = adr;
		wbs_wdata_i = wd;
		wbs_sel_i   = sel;
		wbs_cyc_i   = 1'b1;
		wbs_stb_i   = 1'b1;
		@(negedge axi_clk);
		while (!wbs_ack_o && cnt < WAIT_LIMIT) begin
			if (chk) begin
				watch_bus(adr, exp_en);
			end
			@(negedge axi_clk);
			cnt++;
		end
		if (!wbs_ack_o) begin
			report_timeout("Wishbone ack");
		end
		rd        = wbs_rdata_o;
		wbs_cyc_i = 1'b0;
		wbs_stb_i = 1'b0;
		@(negedge axi_clk);
	endtask

	task automatic fpga_write(input addr_t adr, input data_t wd, input strb_t strb,
			input logic chk, input tgt_en_t exp_en);
		int cnt;
		int hold;
		s_awvalid_i = 1'b1;
		s_awaddr_i  = adr;
		s_wvalid_i  = 1'b1;
		s_wdata_i   = wd;
		s_wstrb_i   = strb;
		cnt         = 0;
		@(negedge axi_clk);
		while (!s_awready_o && cnt < WAIT_LIMIT) begin
			@(negedge axi_clk);
			cnt++;
		end
		if (!s_awready_o) begin
			report_timeout("FPGA port awready");
		end
		s_awvalid_i = 1'b0;
		cnt         = 0;
		while (!s_wready_o && cnt < WAIT_LIMIT) begin
			@(negedge axi_clk);
			cnt++;
		end
		if (!s_wready_o) begin
			report_timeout("FPGA port wready");
		end
		s_wvalid_i = 1'b0;
		cnt        = 0;
		while (!s_bvalid_o && cnt < WAIT_LIMIT) begin
			if (chk) begin
				watch_bus(adr, exp_en);
			end
			@(negedge axi_clk);
			cnt++;
		end
		if (!s_bvalid_o) begin
			report_timeout("FPGA port bvalid");
		end
		hold = $urandom % 4;   // Back-pressure on B
		repeat (hold) begin
			@(negedge axi_clk);
			if (!s_bvalid_o) begin
				$display("FPGA port bvalid fell before bready was raised");
				check_errs++;
			end
		end
		s_bready_i = 1'b1;
		@(negedge axi_clk);
		s_bready_i = 1'b0;
	endtask

	task automatic fpga_read(input addr_t adr, input logic chk, input tgt_en_t exp_en,
			output data_t rd);
		int cnt;
		int hold;
		s_arvalid_i = 1'b1;
		s_araddr_i  = adr;
		cnt         = 0;
		@(negedge axi_clk);
		while (!s_arready_o && cnt < WAIT_LIMIT) begin
			@(negedge axi_clk);
			cnt++;
		end
		if (!s_arready_o) begin
			report_timeout("FPGA port arready");
		end
		s_arvalid_i = 1'b0;
		cnt         = 0;
		while (!s_rvalid_o && cnt < WAIT_LIMIT) begin
			if (chk) begin
				watch_bus(adr, exp_en);
			end
			@(negedge axi_clk);
			cnt++;
		end
		if (!s_rvalid_o) begin
			report_timeout("FPGA port rvalid");
		end
		hold = $urandom % 4;
		repeat (hold) begin
			@(negedge axi_clk);
			if (!s_rvalid_o) begin
				$display("FPGA port rvalid fell before rready was raised");
				check_errs++;
			end
		end
		rd         = s_rdata_o;
		s_rready_i = 1'b1;
		@(negedge axi_clk);
		s_rready_i = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic test_target_pages();
		addr_t a;
		data_t wd;
		data_t rd;
		for (int k = 0; k < `CFG_NUM_TGT; k++) begin
			a  = tgt_addr(k, k + 3);
			wd = $urandom;
			wb_access(1'b1, a, wd, 4'hF, 1'b1, onehot(k), rd);
			note_write(k, k + 3, wd, 4'hF);
			wb_access(1'b0, a, '0, 4'hF, 1'b1, onehot(k), rd);
			check_data("wbs_rdata_o", rd, exp_mem[k][k + 3]);
		end
	endtask

	task automatic test_fpga_targets();
		int    k;
		int    idx;
		data_t wd;
		data_t rd;
		strb_t strb;
		repeat (12) begin
			k    = $urandom % `CFG_NUM_TGT;
			idx  = $urandom % 16;
			wd   = $urandom;
			strb = strb_t'($urandom % 16);   // Partial strobes too
			fpga_write(tgt_addr(k, idx), wd, strb, 1'b1, onehot(k));
			note_write(k, idx, wd, strb);
			fpga_read(tgt_addr(k, idx), 1'b1, onehot(k), rd);
			check_data("s_rdata_o", rd, exp_mem[k][idx]);
		end
	endtask

	task automatic test_select_reg();
		addr_t sel_a;
		data_t wd;
		data_t rd;
		sel_a = {`CFG_LOCAL_PAGE, `CFG_SEL_OFFSET};
		wd    = $urandom;
		wb_access(1'b1, sel_a, wd, 4'hF, 1'b1, '0, rd);
		exp_sel = wd[4:0];
		check_sel("user_prj_sel_o", user_prj_sel_o, exp_sel);
		// Byte lane 0 off, then wrong offset
		wb_access(1'b1, sel_a, ~wd, 4'hE, 1'b1, '0, rd);
		check_sel("user_prj_sel_o", user_prj_sel_o, exp_sel);
		fpga_write(sel_a + 32'h4, ~wd, 4'hF, 1'b1, '0);
		check_sel("user_prj_sel_o", user_prj_sel_o, exp_sel);
		wd = $urandom;
		fpga_write(sel_a, wd, 4'h1, 1'b1, '0);
		exp_sel = wd[4:0];
		check_sel("user_prj_sel_o", user_prj_sel_o, exp_sel);
		wb_access(1'b0, sel_a, '0, 4'hF, 1'b1, '0, rd);
		check_data("wbs_rdata_o", rd, {27'b0, exp_sel});
		fpga_read(sel_a, 1'b1, '0, rd);
		check_data("s_rdata_o", rd, {27'b0, exp_sel});
	endtask

	task automatic test_default_pages();
		addr_t dflt [3];
		data_t rd;
		dflt[0] = 32'h3000_6000;
		dflt[1] = 32'h3FFF_F000;
		dflt[2] = 32'h1234_5678;   // Outside the 0x3 region
		foreach (dflt[i]) begin
			wb_access(1'b1, dflt[i], $urandom, 4'hF, 1'b1, '0, rd);
			wb_access(1'b0, dflt[i], '0, 4'hF, 1'b1, '0, rd);
			check_data("wbs_rdata_o", rd, `CFG_DEFAULT_RDATA);
			fpga_write(dflt[i], $urandom, 4'hF, 1'b1, '0);
			fpga_read(dflt[i], 1'b1, '0, rd);
			check_data("s_rdata_o", rd, `CFG_DEFAULT_RDATA);
		end
	endtask

	// Full sweep of one target through Wishbone
	task automatic check_target(input int k);
		data_t rd;
		for (int idx = 0; idx < 16; idx++) begin
			wb_access(1'b0, tgt_addr(k, idx), '0, 4'hF, 1'b1, onehot(k), rd);
			check_data("wbs_rdata_o", rd, exp_mem[k][idx]);
		end
	endtask

	task automatic test_concurrent();
		data_t wd_wb;
		data_t wd_fp;
		data_t rd_wb;
		data_t rd_fp;
		wd_wb = $urandom;
		wd_fp = $urandom;
		fork
			wb_access(1'b1, tgt_addr(1, 5), wd_wb, 4'hF, 1'b0, '0, rd_wb);
			fpga_write(tgt_addr(3, 9), wd_fp, 4'hF, 1'b0, '0);
		join
		note_write(1, 5, wd_wb, 4'hF);
		note_write(3, 9, wd_fp, 4'hF);
		fork
			wb_access(1'b0, tgt_addr(1, 5), '0, 4'hF, 1'b0, '0, rd_wb);
			fpga_read(tgt_addr(3, 9), 1'b0, '0, rd_fp);
		join
		check_data("wbs_rdata_o", rd_wb, exp_mem[1][5]);
		check_data("s_rdata_o", rd_fp, exp_mem[3][9]);
		check_target(1);
		check_target(3);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h5aea_c3ee));
		check_errs  = 0;
		wait_errs   = 0;
		exp_sel     = '0;
		axi_reset_n = 1'b0;
		wbs_cyc_i   = 1'b0;
		wbs_stb_i   = 1'b0;
		wbs_we_i    = 1'b0;
		wbs_adr_i   = '0;
		wbs_wdata_i = '0;
		wbs_sel_i   = '0;
		s_awvalid_i = 1'b0;
		s_awaddr_i  = '0;
		s_wvalid_i  = 1'b0;
		s_wdata_i   = '0;
		s_wstrb_i   = '0;
		s_bready_i  = 1'b0;
		s_arvalid_i = 1'b0;
		s_araddr_i  = '0;
		s_rready_i  = 1'b0;
		for (int k = 0; k < `CFG_NUM_TGT; k++) begin
			for (int i = 0; i < 16; i++) begin
				exp_mem[k][i] = fill_word(k, i);
			end
		end
		repeat (4) @(negedge axi_clk);
		axi_reset_n = 1'b1;
		@(negedge axi_clk);
		check_en("tgt_en_o", tgt_en_o, '0);
		check_sel("user_prj_sel_o", user_prj_sel_o, '0);

		test_target_pages();
		test_fpga_targets();
		test_select_reg();
		test_default_pages();
		test_concurrent();

		$display("Check errors: %0d, wait timeouts: %0d, assertion failures: %0d",
			check_errs, wait_errs, u_cfg_ctrl.u_asserts.fail_cnt);
		if (check_errs == 0 && wait_errs == 0 && u_cfg_ctrl.u_asserts.fail_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
